// ==== ad2s1210_model.sv ====
// Behavioural resolver-to-digital converter chip model
// Latches angle, speed and fault on falling SAMPLE and shifts out the word
// selected by the address pins, MSB first, changing data on SCLK falling edges

`timescale 1ns/100ps

module ad2s1210_model import resolver_pkg::*; (
    input  logic ss,
    input  logic sclk,
    input  logic sample_n,
    input  logic [1:0] address,
    input  resolver_data_t angle_value,
    input  resolver_data_t speed_value,
    input  fault_t fault_value,
    output logic miso
);

    resolver_data_t angle_latch;
    resolver_data_t speed_latch;
    fault_t fault_latch;
    logic [frame_width-1:0] shift_reg = '0;
    logic clocked = 1'b0;

    assign miso = shift_reg[frame_width-1];

    always @(negedge sample_n) begin
        angle_latch <= angle_value;
        speed_latch <= speed_value;
        fault_latch <= fault_value;
    end

    // The MSB is driven as soon as SS falls
    always @(negedge ss) begin
        clocked <= 1'b0;
        case (address)
            2'b00: shift_reg <= {angle_latch, fault_latch};
            2'b01: shift_reg <= {speed_latch, fault_latch};
            default: shift_reg <= {resolver_data_t'(0), fault_latch};
        endcase
    end

    always @(posedge sclk) begin
        if (!ss) clocked <= 1'b1;
    end

    // The first falling edge comes before any bit was taken, so it does not shift
    always @(negedge sclk) begin
        if (!ss && clocked) shift_reg <= {shift_reg[frame_width-2:0], 1'b0};
    end

endmodule

// ==== read_timer.sv ====
// Periodic read timer for the resolver reader
// Two down-counters issue angle and speed read pulses every period plus one cycles

`timescale 1ns/100ps

module read_timer import resolver_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic enable,
    input  logic [period_width-1:0] angle_period,
    input  logic [period_width-1:0] speed_period,
    output logic angle_request,
    output logic speed_request
);

    // Channel 0 times angle reads and channel 1 speed reads
    logic [period_width-1:0] period [2];
    logic [period_width-1:0] count [2];
    logic [1:0] expired;

    assign period[0] = angle_period;
    assign period[1] = speed_period;

    // A channel fires on the cycle its counter reaches zero
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            expired[i] = enable && (count[i] == '0);
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < 2; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                // Counters sit at their period while disabled so both channels
                // start together once enabled
                if (!enable || expired[i]) begin
                    count[i] <= period[i];
                end else begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

    assign angle_request = expired[0];
    assign speed_request = expired[1];

endmodule

// ==== resolver_asserts.sv ====
// Concurrent checks on the resolver chip pins and result strobes
// Covers SS framing, the SCLK idle level, strobe overlap and address stability

`timescale 1ns/100ps

module resolver_asserts (
    input logic clock,
    input logic reset,
    input logic ss,
    input logic sclk,
    input logic sample_n,
    input logic [1:0] address,
    input logic angle_valid,
    input logic speed_valid
);

    int assertion_failures = 0;

    // The chip must see SAMPLE released before the transfer frame opens
    ss_after_sample: assert property (@(posedge clock) disable iff (!reset)
        $fell(ss) |-> sample_n)
        else begin
            assertion_failures++;
            $error("ss fell while sample_n was low");
        end

    sclk_idle_high: assert property (@(posedge clock) disable iff (!reset)
        ss |-> sclk)
        else begin
            assertion_failures++;
            $error("sclk was low while ss was high");
        end

    single_strobe: assert property (@(posedge clock) disable iff (!reset)
        !(angle_valid && speed_valid))
        else begin
            assertion_failures++;
            $error("angle_valid and speed_valid were high together");
        end

    address_stable: assert property (@(posedge clock) disable iff (!reset)
        !ss |-> $stable(address))
        else begin
            assertion_failures++;
            $error("address changed while ss was low");
        end

endmodule

// ==== resolver_interface.f ====
resolver_pkg.sv
resolver_regs.sv
read_timer.sv
resolver_spi.sv
resolver_sequencer.sv
resolver_interface.sv
ad2s1210_model.sv
resolver_asserts.sv
tb_resolver_interface.sv

// ==== resolver_interface.sv ====
// Resolver-to-digital converter reader, top level
// Connects the register slave, read timer, sequencer and SPI master

`timescale 1ns/100ps

module resolver_interface import resolver_pkg::*; #(
    parameter int SPI_DIVIDER = 2,
    parameter int RESET_CYCLES = 8
) (
    input  logic clock,
    input  logic reset,
    input  reg_address_e bus_address,
    input  logic [bus_data_width-1:0] bus_write_data,
    input  logic bus_write,
    input  logic bus_read,
    output logic [bus_data_width-1:0] bus_read_data,
    output logic bus_read_valid,
    output logic ss,
    output logic sclk,
    output logic mosi,
    input  logic miso,
    output logic [1:0] address,
    output logic [1:0] resolution,
    output logic sample_n,
    output logic reset_n_pin,
    output resolver_data_t angle,
    output logic angle_valid,
    output resolver_data_t speed,
    output logic speed_valid,
    output fault_t fault
);

    logic enable;
    logic [period_width-1:0] angle_period;
    logic [period_width-1:0] speed_period;
    logic [1:0] resolution_setting;
    logic angle_request;
    logic speed_request;
    logic spi_start;
    logic spi_done;
    logic [frame_width-1:0] spi_frame;

    resolver_regs regs (
        .clock(clock), .reset(reset),
        .bus_address(bus_address), .bus_write_data(bus_write_data),
        .bus_write(bus_write), .bus_read(bus_read),
        .angle(angle), .angle_valid(angle_valid),
        .speed(speed), .speed_valid(speed_valid), .fault(fault),
        .bus_read_data(bus_read_data), .bus_read_valid(bus_read_valid),
        .enable(enable), .angle_period(angle_period),
        .speed_period(speed_period), .resolution(resolution_setting)
    );

    read_timer timer (
        .clock(clock), .reset(reset), .enable(enable),
        .angle_period(angle_period), .speed_period(speed_period),
        .angle_request(angle_request), .speed_request(speed_request)
    );

    resolver_sequencer #(.RESET_CYCLES(RESET_CYCLES)) sequencer (
        .clock(clock), .reset(reset),
        .angle_request(angle_request), .speed_request(speed_request),
        .resolution_setting(resolution_setting),
        .spi_done(spi_done), .spi_frame(spi_frame), .spi_start(spi_start),
        .ss(ss), .mosi(mosi), .address(address), .resolution(resolution),
        .sample_n(sample_n), .reset_n_pin(reset_n_pin),
        .angle(angle), .angle_valid(angle_valid),
        .speed(speed), .speed_valid(speed_valid), .fault(fault)
    );

    resolver_spi #(.SPI_DIVIDER(SPI_DIVIDER)) spi (
        .clock(clock), .reset(reset), .start(spi_start), .miso(miso),
        .sclk(sclk), .busy(), .done(spi_done), .frame(spi_frame)
    );

endmodule

// ==== resolver_pkg.sv ====
// Resolver reader shared definitions
// Chip word layout, bus widths, the register map and the sequencer states

package resolver_pkg;

    // The chip returns 16 data bits followed by 8 fault bits
    localparam int data_width = 16;
    localparam int fault_width = 8;
    localparam int frame_width = data_width + fault_width;

    localparam int period_width = 16;
    localparam int bus_data_width = 32;

    typedef logic [data_width-1:0] resolver_data_t;
    typedef logic [fault_width-1:0] fault_t;

    // Register map of the bus slave
    // Last angle and last speed are read only
    typedef enum logic [3:0] {
        reg_control = 4'd0,
        reg_angle_period = 4'd1,
        reg_speed_period = 4'd2,
        reg_last_angle = 4'd3,
        reg_last_speed = 4'd4,
        reg_fault = 4'd5
    } reg_address_e;

    // The read type is also the low bit of the chip address
    typedef enum logic {
        read_angle = 1'b0,
        read_speed = 1'b1
    } read_type_e;

    typedef enum logic [2:0] {
        idle = 3'd0,
        setup = 3'd1,
        sample = 3'd2,
        settle = 3'd3,
        transfer = 3'd4,
        finish = 3'd5
    } sequencer_state_e;

endpackage

// ==== resolver_regs.sv ====
// Resolver reader register bus slave
// Holds control, read periods, last results and the sticky fault byte
// Reads return data one cycle after the read strobe

`timescale 1ns/100ps

module resolver_regs import resolver_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  reg_address_e bus_address,
    input  logic [bus_data_width-1:0] bus_write_data,
    input  logic bus_write,
    input  logic bus_read,
    input  resolver_data_t angle,
    input  logic angle_valid,
    input  resolver_data_t speed,
    input  logic speed_valid,
    input  fault_t fault,
    output logic [bus_data_width-1:0] bus_read_data,
    output logic bus_read_valid,
    output logic enable,
    output logic [period_width-1:0] angle_period,
    output logic [period_width-1:0] speed_period,
    output logic [1:0] resolution
);

    resolver_data_t last_angle;
    resolver_data_t last_speed;
    fault_t sticky_fault;
    fault_t fault_clear;
    fault_t fault_set;
    logic [bus_data_width-1:0] read_word;

    // Writing the fault register clears the bits written as one
    assign fault_clear = (bus_write && bus_address == reg_fault) ?
                         bus_write_data[fault_width-1:0] : '0;
    assign fault_set = (angle_valid || speed_valid) ? fault : '0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable <= 1'b0;
            resolution <= '0;
            angle_period <= '0;
            speed_period <= '0;
            last_angle <= '0;
            last_speed <= '0;
            sticky_fault <= '0;
        end else begin
            if (bus_write) begin
                case (bus_address)
                    reg_control: begin
                        enable <= bus_write_data[0];
                        resolution <= bus_write_data[2:1];
                    end
                    reg_angle_period: angle_period <= bus_write_data[period_width-1:0];
                    reg_speed_period: speed_period <= bus_write_data[period_width-1:0];
                    default: ;
                endcase
            end
            if (angle_valid) last_angle <= angle;
            if (speed_valid) last_speed <= speed;
            // A new fault in the same cycle as a clear wins
            sticky_fault <= (sticky_fault & ~fault_clear) | fault_set;
        end
    end

    always_comb begin
        case (bus_address)
            reg_control: read_word = bus_data_width'({resolution, enable});
            reg_angle_period: read_word = bus_data_width'(angle_period);
            reg_speed_period: read_word = bus_data_width'(speed_period);
            reg_last_angle: read_word = bus_data_width'(last_angle);
            reg_last_speed: read_word = bus_data_width'(last_speed);
            reg_fault: read_word = bus_data_width'(sticky_fault);
            default: read_word = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            bus_read_valid <= 1'b0;
        end else begin
            bus_read_valid <= bus_read;
        end
    end

    always_ff @(posedge clock) begin
        if (bus_read) bus_read_data <= read_word;
    end

endmodule

// ==== resolver_sequencer.sv ====
// Resolver read sequencer
// Drives the chip reset, SAMPLE, address, resolution and SS pins around each
// SPI transfer, arbitrates pending angle and speed reads and routes the
// received data and fault byte to the matching output strobe

`timescale 1ns/100ps

module resolver_sequencer import resolver_pkg::*; #(
    parameter int RESET_CYCLES = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic angle_request,
    input  logic speed_request,
    input  logic [1:0] resolution_setting,
    input  logic spi_done,
    input  logic [frame_width-1:0] spi_frame,
    output logic spi_start,
    output logic ss,
    output logic mosi,
    output logic [1:0] address,
    output logic [1:0] resolution,
    output logic sample_n,
    output logic reset_n_pin,
    output resolver_data_t angle,
    output logic angle_valid,
    output resolver_data_t speed,
    output logic speed_valid,
    output fault_t fault
);

    localparam int reset_count_width = $clog2(RESET_CYCLES + 1);

    sequencer_state_e state;
    read_type_e read_type;
    logic phase;
    logic angle_pending;
    logic speed_pending;
    logic angle_hit;
    logic speed_hit;
    logic [reset_count_width-1:0] reset_count;

    // Requests are dropped until the chip has left reset
    assign angle_hit = angle_request && reset_n_pin;
    assign speed_hit = speed_request && reset_n_pin;

    // Only reads are made so the chip data input stays low
    assign mosi = 1'b0;

    always_ff @(posedge clock) begin
        if (!reset) begin
            reset_count <= '0;
            reset_n_pin <= 1'b0;
        end else if (!reset_n_pin) begin
            if (reset_count == reset_count_width'(RESET_CYCLES - 1)) begin
                reset_n_pin <= 1'b1;
            end else begin
                reset_count <= reset_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            read_type <= read_angle;
            phase <= 1'b0;
            angle_pending <= 1'b0;
            speed_pending <= 1'b0;
            address <= '0;
            resolution <= '0;
            ss <= 1'b1;
            sample_n <= 1'b1;
            spi_start <= 1'b0;
            angle_valid <= 1'b0;
            speed_valid <= 1'b0;
        end else begin
            spi_start <= 1'b0;
            angle_valid <= 1'b0;
            speed_valid <= 1'b0;
            // Repeated requests of one type merge into a single pending flag
            if (angle_hit) angle_pending <= 1'b1;
            if (speed_hit) speed_pending <= 1'b1;
            case (state)
                idle: begin
                    // Resolution pins only move between conversions
                    resolution <= resolution_setting;
                    if (angle_pending || angle_hit) begin
                        read_type <= read_angle;
                        address <= {1'b0, read_angle};
                        angle_pending <= 1'b0;
                        state <= setup;
                    end else if (speed_pending || speed_hit) begin
                        read_type <= read_speed;
                        address <= {1'b0, read_speed};
                        speed_pending <= 1'b0;
                        state <= setup;
                    end
                end
                setup: begin
                    sample_n <= 1'b0;
                    phase <= 1'b0;
                    state <= sample;
                end
                sample: begin
                    phase <= ~phase;
                    if (phase) begin
                        sample_n <= 1'b1;
                        state <= settle;
                    end
                end
                settle: begin
                    phase <= ~phase;
                    if (phase) begin
                        ss <= 1'b0;
                        spi_start <= 1'b1;
                        state <= transfer;
                    end
                end
                transfer: begin
                    if (spi_done) begin
                        ss <= 1'b1;
                        angle_valid <= (read_type == read_angle);
                        speed_valid <= (read_type == read_speed);
                        state <= finish;
                    end
                end
                finish: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    // Split the frame into data and fault and steer the data by read type
    always_ff @(posedge clock) begin
        if (state == transfer && spi_done) begin
            fault <= spi_frame[fault_width-1:0];
            if (read_type == read_angle) begin
                angle <= spi_frame[frame_width-1 -: data_width];
            end else begin
                speed <= spi_frame[frame_width-1 -: data_width];
            end
        end
    end

endmodule

// ==== resolver_spi.sv ====
// SPI master for the resolver chip
// Clocks in one 24-bit word MSB first, SCLK idles high and miso is
// sampled on rising edges. Done pulses 48 divider periods after start

`timescale 1ns/100ps

module resolver_spi import resolver_pkg::*; #(
    parameter int SPI_DIVIDER = 2
) (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic miso,
    output logic sclk,
    output logic busy,
    output logic done,
    output logic [frame_width-1:0] frame
);

    localparam int div_width = (SPI_DIVIDER > 1) ? $clog2(SPI_DIVIDER) : 1;
    localparam int half_periods = 2 * frame_width;
    localparam int half_width = $clog2(half_periods);

    logic [div_width-1:0] div_count;
    logic [half_width-1:0] half_count;
    logic [frame_width-1:0] shift_reg;
    logic half_end;
    logic last_half;

    assign half_end = (div_count == div_width'(SPI_DIVIDER - 1));
    assign last_half = (half_count == half_width'(half_periods - 1));

    // The last half period is the high phase after the final rising edge,
    // so the word is already complete when done is raised
    assign done = busy && half_end && last_half;
    assign frame = shift_reg;

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
            sclk <= 1'b1;
            div_count <= '0;
            half_count <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                sclk <= 1'b0;
                div_count <= '0;
                half_count <= '0;
            end
        end else if (half_end) begin
            div_count <= '0;
            if (last_half) begin
                busy <= 1'b0;
            end else begin
                half_count <= half_count + 1'b1;
                sclk <= ~sclk;
            end
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // Sample on the rising edge, which ends each low half period
    always_ff @(posedge clock) begin
        if (busy && half_end && !sclk) begin
            shift_reg <= {shift_reg[frame_width-2:0], miso};
        end
    end

endmodule

// ==== tb_resolver_interface.sv ====
// Testbench for the resolver reader top level
// Chip values and register settings come from an LCG, and every result is
// checked against the chip values latched at the preceding SAMPLE

`timescale 1ns/100ps

module tb_resolver_interface import resolver_pkg::*; ();

    localparam int spi_divider = 2;
    localparam int reset_cycles = 8;
    localparam int timeout_cycles = 30 * (10 + 48 * spi_divider) + 2000;

    logic clock;
    logic reset;
    reg_address_e bus_address;
    logic [bus_data_width-1:0] bus_write_data;
    logic bus_write;
    logic bus_read;
    logic [bus_data_width-1:0] bus_read_data;
    logic bus_read_valid;
    logic ss, sclk, mosi, miso, sample_n, reset_n_pin;
    logic [1:0] address;
    logic [1:0] resolution;
    resolver_data_t angle, speed;
    logic angle_valid, speed_valid;
    fault_t fault;

    logic [31:0] stim_state = 32'd93;
    logic [31:0] chip_state = ~32'd93;
    resolver_data_t chip_angle, chip_speed, snap_angle, snap_speed;
    resolver_data_t model_last_angle = '0;
    resolver_data_t model_last_speed = '0;
    fault_t chip_fault, snap_fault;
    fault_t model_sticky = '0;
    read_type_e next_type = read_angle;
    logic alternate = 1'b0;
    logic prev_ss = 1'b1;
    logic [1:0] resolution_value = '0;
    int angle_count = 0;
    int speed_count = 0;
    int ss_falls = 0;
    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start;
    int cycle_count;
    string test_name;

    resolver_interface #(.SPI_DIVIDER(spi_divider), .RESET_CYCLES(reset_cycles)) DUT (.*);

    ad2s1210_model chip (
        .ss(ss), .sclk(sclk), .sample_n(sample_n), .address(address),
        .angle_value(chip_angle), .speed_value(chip_speed), .fault_value(chip_fault),
        .miso(miso)
    );

    bind resolver_interface resolver_asserts asserts (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] random16();
        stim_state = lcg_next(stim_state);
        return stim_state[31:16];
    endfunction

    function automatic int total_errors();
        return error_count + DUT.asserts.assertion_failures;
    endfunction

    task automatic check_data(input string name, input resolver_data_t actual,
                              input resolver_data_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_fault(input string name, input fault_t actual, input fault_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_bus_word(input string name, input logic [bus_data_width-1:0] actual,
                                  input logic [bus_data_width-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_error(input string text);
        $display("ERROR in %s: %s", test_name, text);
        error_count++;
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("ERROR: run stopped by the timeout after %0d cycles", cycle_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // New chip values every cycle and the model keeps whatever is there at SAMPLE
    always @(negedge clock) begin
        chip_state = lcg_next(chip_state);
        chip_angle = chip_state[31:16];
        chip_state = lcg_next(chip_state);
        chip_speed = chip_state[31:16];
        chip_fault = chip_state[15:8] & chip_state[23:16];
    end

    always @(negedge sample_n) begin
        snap_angle = chip_angle;
        snap_speed = chip_speed;
        snap_fault = chip_fault;
    end

    task automatic take_result(input read_type_e kind, input resolver_data_t value);
        if (kind != next_type) report_error($sformatf("%s result out of order", kind.name()));
        check_data(kind == read_angle ? "angle" : "speed", value,
                   kind == read_angle ? snap_angle : snap_speed);
        check_fault("fault", fault, snap_fault);
        if (kind == read_angle) model_last_angle = snap_angle;
        else model_last_speed = snap_speed;
        model_sticky = model_sticky | snap_fault;
        if (alternate) next_type = (kind == read_angle) ? read_speed : read_angle;
    endtask

    always @(negedge clock) begin
        if (reset) begin
            if (prev_ss && !ss) begin
                ss_falls++;
                check_bus_word("address", 32'(address), 32'(next_type));
            end
            // No configuration writes are made so the chip data input stays low
            if (!ss) check_bus_word("mosi", 32'(mosi), 32'd0);
            if (angle_valid) begin
                angle_count++;
                take_result(read_angle, angle);
            end
            if (speed_valid) begin
                speed_count++;
                take_result(read_speed, speed);
            end
        end
        prev_ss = ss;
    end

    task automatic write_register(input reg_address_e target,
                                  input logic [bus_data_width-1:0] data);
        bus_address = target;
        bus_write_data = data;
        bus_write = 1'b1;
        @(negedge clock);
        bus_write = 1'b0;
    endtask

    task automatic expect_register(input reg_address_e target,
                                   input logic [bus_data_width-1:0] expected);
        bus_address = target;
        bus_read = 1'b1;
        @(negedge clock);
        bus_read = 1'b0;
        if (!bus_read_valid) report_error("bus_read_valid missing one cycle after bus_read");
        check_bus_word($sformatf("bus_read_data at address %0d", target), bus_read_data,
                       expected);
    endtask

    task automatic start_reads(input logic [15:0] angle_period, input logic [15:0] speed_period);
        write_register(reg_angle_period, angle_period);
        write_register(reg_speed_period, speed_period);
        write_register(reg_control, {resolution_value, 1'b1});
    endtask

    // Clears enable and lets the read in flight complete
    task automatic stop_reads();
        write_register(reg_control, {resolution_value, 1'b0});
        while (!ss) @(negedge clock);
        repeat (20) @(negedge clock);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = total_errors();
        tests_run++;
    endtask

    task automatic end_test();
        if (total_errors() == errors_at_start) begin
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d errors", test_name, total_errors() - errors_at_start);
        end
    endtask

    task automatic registers_readback();
        logic [15:0] angle_period;
        logic [15:0] speed_period;
        int wait_count;
        start_test("register readback");
        if (reset_n_pin) report_error("reset_n_pin was high straight after reset");
        wait_count = 0;
        while (!reset_n_pin && wait_count < reset_cycles + 2) begin
            @(negedge clock);
            wait_count++;
        end
        if (!reset_n_pin) report_error("reset_n_pin stayed low after the chip reset time");
        expect_register(reg_control, '0);
        expect_register(reg_fault, '0);
        expect_register(reg_address_e'(4'd9), '0);
        angle_period = random16();
        speed_period = random16();
        resolution_value = 2'(random16());
        write_register(reg_angle_period, angle_period);
        write_register(reg_speed_period, speed_period);
        write_register(reg_control, {resolution_value, 1'b0});
        expect_register(reg_angle_period, angle_period);
        expect_register(reg_speed_period, speed_period);
        expect_register(reg_control, {resolution_value, 1'b0});
        check_bus_word("resolution", 32'(resolution), 32'(resolution_value));
        end_test();
    endtask

    // The idle channel gets the longest period so it never fires in the window
    task automatic single_channel_reads(input read_type_e channel);
        int angle_start;
        int speed_start;
        logic [15:0] period;
        start_test(channel == read_angle ? "angle reads" : "speed reads");
        period = 16'(120 + random16() % 64);
        next_type = channel;
        alternate = 1'b0;
        angle_start = angle_count;
        speed_start = speed_count;
        if (channel == read_angle) begin
            start_reads(period, 16'hffff);
            while (angle_count < angle_start + 6) @(negedge clock);
        end else begin
            start_reads(16'hffff, period);
            while (speed_count < speed_start + 6) @(negedge clock);
        end
        stop_reads();
        if (channel == read_angle && speed_count != speed_start)
            report_error("a speed result appeared during angle reads");
        if (channel == read_speed && angle_count != angle_start)
            report_error("an angle result appeared during speed reads");
        end_test();
    endtask

    task automatic paired_reads();
        int angle_start;
        int speed_start;
        logic [15:0] period;
        start_test("both channels due together");
        period = 16'(260 + random16() % 64);
        next_type = read_angle;
        alternate = 1'b1;
        angle_start = angle_count;
        speed_start = speed_count;
        start_reads(period, period);
        while (speed_count < speed_start + 3) @(negedge clock);
        stop_reads();
        if (angle_count - angle_start != 3 || speed_count - speed_start != 3)
            report_error("three request pairs did not give three angle and three speed results");
        end_test();
    endtask

    task automatic result_registers();
        logic [15:0] mask;
        start_test("result registers");
        expect_register(reg_last_angle, model_last_angle);
        expect_register(reg_last_speed, model_last_speed);
        expect_register(reg_fault, model_sticky);
        mask = random16() & 16'h00ff;
        write_register(reg_fault, mask);
        model_sticky = model_sticky & ~fault_t'(mask);
        expect_register(reg_fault, model_sticky);
        end_test();
    endtask

    task automatic disable_stops_reads();
        int angle_start;
        int speed_start;
        int falls_start;
        start_test("disable");
        next_type = read_angle;
        alternate = 1'b0;
        angle_start = angle_count;
        start_reads(16'd150, 16'hffff);
        while (ss) @(negedge clock);
        write_register(reg_control, {resolution_value, 1'b0});
        while (!ss) @(negedge clock);
        repeat (5) @(negedge clock);
        if (angle_count != angle_start + 1)
            report_error("the read in flight when enable was cleared did not finish");
        angle_start = angle_count;
        speed_start = speed_count;
        falls_start = ss_falls;
        repeat (500) @(negedge clock);
        if (angle_count != angle_start || speed_count != speed_start || ss_falls != falls_start)
            report_error("a read started while enable was clear");
        end_test();
    endtask

    initial begin
        reset = 1'b0;
        bus_address = reg_control;
        bus_write_data = '0;
        bus_write = 1'b0;
        bus_read = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        registers_readback();
        single_channel_reads(read_angle);
        single_channel_reads(read_speed);
        paired_reads();
        result_registers();
        disable_stops_reads();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors());
        if (total_errors() == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
